// ==== Makefile ====
TOP = vwrite_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f vwrite.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f vwrite.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q ">>> PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== hw/buffer_reader.sv ====
`timescale 1ns/1ps

module buffer_reader #(
   parameter int DATA_W = vwrite_pkg::DEF_DATA_W,
   parameter int ADDR_W = vwrite_pkg::DEF_ADDR_W
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              flush_i,
   input  logic              req_valid_i,
   output logic              req_ready_o,
   input  logic [ADDR_W-1:0] req_addr_i,
   input  logic              req_last_i,
   output logic              mem_re_o,
   output logic [ADDR_W-1:0] mem_addr_o,
   input  logic [DATA_W-1:0] mem_data_i,
   vwrite_stream_if.source   out
);

   logic [DATA_W-1:0] skid_data [2];
   logic [1:0]        skid_last;
   logic              wr_ptr;
   logic              rd_ptr;
   logic [1:0]        count;
   logic              inflight;
   logic              inflight_last;
   logic [1:0]        occupancy;
   logic              pop;
   logic              accept;

   // stored words plus the one coming back from the buffer
   assign occupancy = count + {1'b0, inflight};
   assign pop       = out.valid && out.ready;

   assign req_ready_o = !flush_i && ((occupancy < 2'd2) || pop);
   assign accept      = req_valid_i && req_ready_o;
   assign mem_re_o    = accept;
   assign mem_addr_o  = req_addr_i;

   assign out.valid     = (count != 2'd0);
   assign out.data      = skid_data[rd_ptr];
   assign out.last_word = skid_last[rd_ptr];

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wr_ptr   <= 1'b0;
         rd_ptr   <= 1'b0;
         count    <= 2'd0;
         inflight <= 1'b0;
      end else if (flush_i) begin
         wr_ptr   <= 1'b0;
         rd_ptr   <= 1'b0;
         count    <= 2'd0;
         inflight <= 1'b0;
      end else begin
         inflight <= accept;
         if (inflight) begin
            wr_ptr <= ~wr_ptr;
         end
         if (pop) begin
            rd_ptr <= ~rd_ptr;
         end
         count <= count + {1'b0, inflight} - {1'b0, pop};
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         inflight_last <= req_last_i;
      end
      // capture the buffer word one cycle after its read
      if (inflight) begin
         skid_data[wr_ptr] <= mem_data_i;
         skid_last[wr_ptr] <= inflight_last;
      end
   end

endmodule

// ==== hw/burst_writer.sv ====
`timescale 1ns/1ps

module burst_writer #(
   parameter int DATA_W     = vwrite_pkg::DEF_DATA_W,
   parameter int AXI_ADDR_W = vwrite_pkg::DEF_AXI_ADDR_W,
   parameter int LEN_W      = vwrite_pkg::DEF_LEN_W
) (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  run_i,
   input  logic [AXI_ADDR_W-1:0] ext_addr_i,
   input  logic [LEN_W-1:0]      count_i,
   input  logic [LEN_W-1:0]      length_i,
   vwrite_stream_if.sink         in,
   output logic                  databus_valid_o,
   input  logic                  databus_ready_i,
   output logic [AXI_ADDR_W-1:0] databus_addr_o,
   output logic [DATA_W-1:0]     databus_wdata_o,
   output logic [LEN_W-1:0]      databus_len_o,
   input  logic                  databus_last_i,
   output logic                  done_o
);

   import vwrite_pkg::*;

   localparam logic [AXI_ADDR_W-1:0] WORD_BYTES = AXI_ADDR_W'(BYTES_PER_WORD);

   logic [LEN_W-1:0]      remaining;
   logic [LEN_W-1:0]      cur_len;
   logic [AXI_ADDR_W-1:0] burst_addr;
   logic                  active;
   logic                  beat;
   logic                  burst_end;

   // remaining only moves at a burst end, so len stays put within a burst
   assign cur_len = (length_i < remaining) ? length_i : remaining;

   assign databus_valid_o = active && in.valid;
   assign in.ready        = active && databus_ready_i;
   assign databus_addr_o  = burst_addr;
   assign databus_len_o   = cur_len;
   assign databus_wdata_o = in.data;

   assign beat      = databus_valid_o && databus_ready_i;
   assign burst_end = beat && databus_last_i;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         active     <= 1'b0;
         done_o     <= 1'b1;
         remaining  <= '0;
         burst_addr <= '0;
      end else if (run_i) begin
         active     <= 1'b1;
         done_o     <= 1'b0;
         remaining  <= count_i;
         burst_addr <= ext_addr_i;
      end else if (burst_end) begin
         remaining  <= remaining - cur_len;
         burst_addr <= burst_addr + AXI_ADDR_W'(cur_len) * WORD_BYTES;
         // block ends with the burst that carries its last word
         if (in.last_word) begin
            active <= 1'b0;
            done_o <= 1'b1;
         end
      end
   end

endmodule

// ==== hw/dual_port_buffer.sv ====
`timescale 1ns/1ps

module dual_port_buffer #(
   parameter int DATA_W = vwrite_pkg::DEF_DATA_W,
   parameter int ADDR_W = vwrite_pkg::DEF_ADDR_W
) (
   input  logic              clk,
   input  logic              we_i,
   input  logic [ADDR_W-1:0] waddr_i,
   input  logic [DATA_W-1:0] wdata_i,
   input  logic              re_i,
   input  logic [ADDR_W-1:0] raddr_i,
   output logic [DATA_W-1:0] rdata_o
);

   logic [DATA_W-1:0] mem [2**ADDR_W];

   always_ff @(posedge clk) begin
      if (we_i) begin
         mem[waddr_i] <= wdata_i;
      end
   end

   // read data valid one cycle after re_i
   always_ff @(posedge clk) begin
      if (re_i) begin
         rdata_o <= mem[raddr_i];
      end
   end

endmodule

// ==== hw/store_addr_gen.sv ====
`timescale 1ns/1ps

module store_addr_gen #(
   parameter int ADDR_W   = vwrite_pkg::DEF_ADDR_W,
   parameter int PERIOD_W = vwrite_pkg::DEF_PERIOD_W,
   parameter int DELAY_W  = vwrite_pkg::DEF_DELAY_W
) (
   input  logic                clk,
   input  logic                rst,
   input  logic                run_i,
   input  logic                running_i,
   input  logic [ADDR_W-1:0]   start_i,
   input  logic [ADDR_W-1:0]   incr_i,
   input  logic [ADDR_W-1:0]   shift_i,
   input  logic [ADDR_W-1:0]   iter_i,
   input  logic [PERIOD_W-1:0] per_i,
   input  logic [PERIOD_W-1:0] duty_i,
   input  logic [DELAY_W-1:0]  delay_i,
   output logic                we_o,
   output logic [ADDR_W-1:0]   addr_o,
   output logic                done_o
);

   logic                busy;
   logic [DELAY_W-1:0]  delay_cnt;
   logic [PERIOD_W-1:0] per_cnt;
   logic [ADDR_W-1:0]   iter_cnt;
   logic [ADDR_W-1:0]   addr;
   logic                active;
   logic                per_end;
   logic                iter_end;

   // zero period or iteration count behaves as one
   assign per_end  = (per_i == '0) || (per_cnt == per_i - 1'b1);
   assign iter_end = (iter_i == '0) || (iter_cnt == iter_i - 1'b1);

   assign active = busy && running_i && (delay_cnt == '0);
   assign we_o   = active && (per_cnt < duty_i);
   assign addr_o = addr;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         busy      <= 1'b0;
         delay_cnt <= '0;
         per_cnt   <= '0;
         iter_cnt  <= '0;
         addr      <= '0;
         done_o    <= 1'b1;
      end else if (run_i) begin
         busy      <= 1'b1;
         delay_cnt <= delay_i;
         per_cnt   <= '0;
         iter_cnt  <= '0;
         addr      <= start_i;
         done_o    <= 1'b0;
      end else if (busy && running_i) begin
         if (delay_cnt != '0) begin
            delay_cnt <= delay_cnt - 1'b1;
         end else if (per_end) begin
            // period end adds shift on top of the usual incr
            per_cnt <= '0;
            addr    <= addr + incr_i + shift_i;
            if (iter_end) begin
               busy   <= 1'b0;
               done_o <= 1'b1;
            end else begin
               iter_cnt <= iter_cnt + 1'b1;
            end
         end else begin
            per_cnt <= per_cnt + 1'b1;
            addr    <= addr + incr_i;
         end
      end
   end

endmodule

// ==== hw/vwrite_ctrl.sv ====
`timescale 1ns/1ps

module vwrite_ctrl #(
   parameter int ADDR_W = vwrite_pkg::DEF_ADDR_W
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              run_i,
   input  logic              running_i,
   input  logic              enabled_i,
   input  logic              ping_pong_i,
   input  logic [ADDR_W-1:0] amount_minus_one_i,
   input  logic              store_done_i,
   input  logic              drain_done_i,
   output logic              req_valid_o,
   input  logic              req_ready_i,
   output logic [ADDR_W-1:0] req_addr_o,
   output logic              req_last_o,
   output logic              store_half_o,
   output logic              done_o
);

   logic              half;
   logic              req_active;
   logic              drain_en;
   logic [ADDR_W-1:0] cnt;
   logic              req_fire;

   assign req_fire    = req_active && req_ready_i;
   assign req_valid_o = req_active;
   assign req_last_o  = (cnt == amount_minus_one_i);

   // drain reads the half that is not being stored this run
   assign req_addr_o   = ping_pong_i ? {~half, cnt[ADDR_W-2:0]} : cnt;
   assign store_half_o = half;

   // a disabled drain counts as finished
   assign done_o = store_done_i && (drain_done_i || !drain_en);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         half <= 1'b0;
      end else if (run_i) begin
         half <= ping_pong_i ? ~half : 1'b0;
      end
   end

   // drain address issue, 0 up to amount_minus_one
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         req_active <= 1'b0;
         drain_en   <= 1'b0;
         cnt        <= '0;
      end else if (run_i) begin
         req_active <= enabled_i;
         drain_en   <= enabled_i;
         cnt        <= '0;
      end else if (!running_i) begin
         req_active <= 1'b0;
      end else if (req_fire) begin
         if (req_last_o) begin
            req_active <= 1'b0;
         end else begin
            cnt <= cnt + 1'b1;
         end
      end
   end

endmodule

// ==== hw/vwrite_pkg.sv ====
package vwrite_pkg;

   // datapath and databus word width
   localparam int DEF_DATA_W = 32;

   // buffer is word addressed, top bit selects the ping-pong half
   localparam int DEF_ADDR_W = 8;

   localparam int DEF_AXI_ADDR_W = 32;

   // burst length and block word count
   localparam int DEF_LEN_W = 8;

   // period and duty counters of the store generator
   localparam int DEF_PERIOD_W = 6;

   localparam int DEF_DELAY_W = 6;

   // byte step of one databus beat
   localparam int BYTES_PER_WORD = DEF_DATA_W / 8;

endpackage

// ==== hw/vwrite_stream_if.sv ====
`timescale 1ns/1ps

interface vwrite_stream_if #(
   parameter int DATA_W = vwrite_pkg::DEF_DATA_W
) ();

   logic              valid;
   logic              ready;
   logic [DATA_W-1:0] data;
   // marks the final word of the drain block
   logic              last_word;

   modport source (
      output valid,
      output data,
      output last_word,
      input  ready
   );

   modport sink (
      input  valid,
      input  data,
      input  last_word,
      output ready
   );

endinterface

// ==== hw/vwrite_top.sv ====
`timescale 1ns/1ps

module vwrite_top #(
   parameter int DATA_W     = vwrite_pkg::DEF_DATA_W,
   parameter int ADDR_W     = vwrite_pkg::DEF_ADDR_W,
   parameter int AXI_ADDR_W = vwrite_pkg::DEF_AXI_ADDR_W,
   parameter int LEN_W      = vwrite_pkg::DEF_LEN_W,
   parameter int PERIOD_W   = vwrite_pkg::DEF_PERIOD_W,
   parameter int DELAY_W    = vwrite_pkg::DEF_DELAY_W
) (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  run_i,
   input  logic                  running_i,
   input  logic                  enabled_i,
   input  logic                  ping_pong_i,
   input  logic [DATA_W-1:0]     in_data_i,
   input  logic [AXI_ADDR_W-1:0] ext_addr_i,
   input  logic [ADDR_W-1:0]     amount_minus_one_i,
   input  logic [LEN_W-1:0]      length_i,
   input  logic [ADDR_W-1:0]     start_i,
   input  logic [ADDR_W-1:0]     incr_i,
   input  logic [ADDR_W-1:0]     shift_i,
   input  logic [ADDR_W-1:0]     iter_i,
   input  logic [PERIOD_W-1:0]   per_i,
   input  logic [PERIOD_W-1:0]   duty_i,
   input  logic [DELAY_W-1:0]    delay_i,
   output logic                  done_o,
   output logic                  databus_valid_o,
   input  logic                  databus_ready_i,
   output logic [AXI_ADDR_W-1:0] databus_addr_o,
   output logic [DATA_W-1:0]     databus_wdata_o,
   output logic [LEN_W-1:0]      databus_len_o,
   input  logic                  databus_last_i
);

   logic              store_done;
   logic              drain_done;
   logic              store_half;
   logic              store_we;
   logic [ADDR_W-1:0] gen_addr;
   logic [ADDR_W-1:0] store_addr;
   logic              req_valid;
   logic              req_ready;
   logic [ADDR_W-1:0] req_addr;
   logic              req_last;
   logic              mem_re;
   logic [ADDR_W-1:0] mem_raddr;
   logic [DATA_W-1:0] mem_rdata;
   logic [LEN_W-1:0]  block_count;

   vwrite_stream_if #(.DATA_W(DATA_W)) word_stream ();

   // ping-pong half overrides the generator's top bit
   assign store_addr  = {ping_pong_i ? store_half : gen_addr[ADDR_W-1], gen_addr[ADDR_W-2:0]};
   assign block_count = LEN_W'(amount_minus_one_i) + 1'b1;

   vwrite_ctrl #(
      .ADDR_W(ADDR_W)
   ) u_ctrl (
      .clk               (clk),
      .rst               (rst),
      .run_i             (run_i),
      .running_i         (running_i),
      .enabled_i         (enabled_i),
      .ping_pong_i       (ping_pong_i),
      .amount_minus_one_i(amount_minus_one_i),
      .store_done_i      (store_done),
      .drain_done_i      (drain_done),
      .req_valid_o       (req_valid),
      .req_ready_i       (req_ready),
      .req_addr_o        (req_addr),
      .req_last_o        (req_last),
      .store_half_o      (store_half),
      .done_o            (done_o)
   );

   store_addr_gen #(
      .ADDR_W  (ADDR_W),
      .PERIOD_W(PERIOD_W),
      .DELAY_W (DELAY_W)
   ) u_store_gen (
      .clk      (clk),
      .rst      (rst),
      .run_i    (run_i),
      .running_i(running_i),
      .start_i  (start_i),
      .incr_i   (incr_i),
      .shift_i  (shift_i),
      .iter_i   (iter_i),
      .per_i    (per_i),
      .duty_i   (duty_i),
      .delay_i  (delay_i),
      .we_o     (store_we),
      .addr_o   (gen_addr),
      .done_o   (store_done)
   );

   dual_port_buffer #(
      .DATA_W(DATA_W),
      .ADDR_W(ADDR_W)
   ) u_buffer (
      .clk    (clk),
      .we_i   (store_we),
      .waddr_i(store_addr),
      .wdata_i(in_data_i),
      .re_i   (mem_re),
      .raddr_i(mem_raddr),
      .rdata_o(mem_rdata)
   );

   // a new run or a dropped running level empties the reader
   buffer_reader #(
      .DATA_W(DATA_W),
      .ADDR_W(ADDR_W)
   ) u_reader (
      .clk        (clk),
      .rst        (rst),
      .flush_i    (run_i || !running_i),
      .req_valid_i(req_valid),
      .req_ready_o(req_ready),
      .req_addr_i (req_addr),
      .req_last_i (req_last),
      .mem_re_o   (mem_re),
      .mem_addr_o (mem_raddr),
      .mem_data_i (mem_rdata),
      .out        (word_stream)
   );

   burst_writer #(
      .DATA_W    (DATA_W),
      .AXI_ADDR_W(AXI_ADDR_W),
      .LEN_W     (LEN_W)
   ) u_writer (
      .clk            (clk),
      .rst            (rst),
      .run_i          (run_i && enabled_i),
      .ext_addr_i     (ext_addr_i),
      .count_i        (block_count),
      .length_i       (length_i),
      .in             (word_stream),
      .databus_valid_o(databus_valid_o),
      .databus_ready_i(databus_ready_i),
      .databus_addr_o (databus_addr_o),
      .databus_wdata_o(databus_wdata_o),
      .databus_len_o  (databus_len_o),
      .databus_last_i (databus_last_i),
      .done_o         (drain_done)
   );

endmodule

// ==== verif/vwrite_chk.sv ====
`timescale 1ns/1ps

module vwrite_chk #(
   parameter int DATA_W     = vwrite_pkg::DEF_DATA_W,
   parameter int AXI_ADDR_W = vwrite_pkg::DEF_AXI_ADDR_W,
   parameter int LEN_W      = vwrite_pkg::DEF_LEN_W
) (
   input logic                  clk,
   input logic                  rst,
   input logic                  valid_i,
   input logic                  ready_i,
   input logic                  last_i,
   input logic [AXI_ADDR_W-1:0] addr_i,
   input logic [LEN_W-1:0]      len_i,
   input logic [DATA_W-1:0]     data_i,
   input logic                  done_i
);

   int failures = 0;

   // a stalled beat stays offered with the same word
   valid_held: assert property (@(posedge clk) disable iff (rst)
      valid_i && !ready_i |=> valid_i && $stable(data_i))
      else begin
         failures++;
         $error("databus valid dropped or data changed while waiting for ready");
      end

   // burst address and length only move after the last beat
   burst_fields_stable: assert property (@(posedge clk) disable iff (rst)
      valid_i && !(ready_i && last_i) |=> $stable(addr_i) && $stable(len_i))
      else begin
         failures++;
         $error("databus address or length changed inside a burst");
      end

   done_low_while_valid: assert property (@(posedge clk) disable iff (rst)
      valid_i |-> !done_i)
      else begin
         failures++;
         $error("done high while a databus beat is offered");
      end

endmodule

// ==== verif/vwrite_tb.sv ====
`timescale 1ns/1ps

module vwrite_tb;

   import vwrite_pkg::*;

   localparam int DATA_W     = DEF_DATA_W;
   localparam int ADDR_W     = DEF_ADDR_W;
   localparam int AXI_ADDR_W = DEF_AXI_ADDR_W;
   localparam int LEN_W      = DEF_LEN_W;
   localparam int PERIOD_W   = DEF_PERIOD_W;
   localparam int DELAY_W    = DEF_DELAY_W;
   localparam int CLK_PERIOD = 20;
   localparam int NUM_RUNS   = 40;
   localparam int HALF_WORDS = 2 ** (ADDR_W - 1);
   // longest store of 63 delay and 8 x 16 steps plus a stalled 128 word drain
   localparam int RUN_CYCLES = 600;
   localparam int WATCHDOG_CYCLES = (NUM_RUNS + 2) * RUN_CYCLES + 10;

   logic                  clk;
   logic                  rst;
   logic                  run_i;
   logic                  running_i;
   logic                  enabled_i;
   logic                  ping_pong_i;
   logic [DATA_W-1:0]     in_data_i;
   logic [AXI_ADDR_W-1:0] ext_addr_i;
   logic [ADDR_W-1:0]     amount_minus_one_i;
   logic [LEN_W-1:0]      length_i;
   logic [ADDR_W-1:0]     start_i;
   logic [ADDR_W-1:0]     incr_i;
   logic [ADDR_W-1:0]     shift_i;
   logic [ADDR_W-1:0]     iter_i;
   logic [PERIOD_W-1:0]   per_i;
   logic [PERIOD_W-1:0]   duty_i;
   logic [DELAY_W-1:0]    delay_i;
   logic                  done_o;
   logic                  databus_valid_o;
   logic                  databus_ready_i;
   logic [AXI_ADDR_W-1:0] databus_addr_o;
   logic [DATA_W-1:0]     databus_wdata_o;
   logic [LEN_W-1:0]      databus_len_o;
   logic                  databus_last_i;

   int seed = 95;
   int errors = 0;
   int checks = 0;
   int beats;

   // reference image of the buffer and the ping-pong half
   logic [DATA_W-1:0]     model_mem [2**ADDR_W];
   logic                  model_half;
   logic [AXI_ADDR_W-1:0] exp_addr_q [$];
   logic [LEN_W-1:0]      exp_len_q [$];
   logic [DATA_W-1:0]     exp_data_q [$];
   logic                  exp_final_q [$];
   logic                  store_we_q [$];
   logic [ADDR_W-1:0]     store_addr_q [$];

   vwrite_top #(
      .DATA_W    (DATA_W),
      .ADDR_W    (ADDR_W),
      .AXI_ADDR_W(AXI_ADDR_W),
      .LEN_W     (LEN_W),
      .PERIOD_W  (PERIOD_W),
      .DELAY_W   (DELAY_W)
   ) DUT (
      .clk               (clk),
      .rst               (rst),
      .run_i             (run_i),
      .running_i         (running_i),
      .enabled_i         (enabled_i),
      .ping_pong_i       (ping_pong_i),
      .in_data_i         (in_data_i),
      .ext_addr_i        (ext_addr_i),
      .amount_minus_one_i(amount_minus_one_i),
      .length_i          (length_i),
      .start_i           (start_i),
      .incr_i            (incr_i),
      .shift_i           (shift_i),
      .iter_i            (iter_i),
      .per_i             (per_i),
      .duty_i            (duty_i),
      .delay_i           (delay_i),
      .done_o            (done_o),
      .databus_valid_o   (databus_valid_o),
      .databus_ready_i   (databus_ready_i),
      .databus_addr_o    (databus_addr_o),
      .databus_wdata_o   (databus_wdata_o),
      .databus_len_o     (databus_len_o),
      .databus_last_i    (databus_last_i)
   );

   bind vwrite_top vwrite_chk #(
      .DATA_W    (DATA_W),
      .AXI_ADDR_W(AXI_ADDR_W),
      .LEN_W     (LEN_W)
   ) u_chk (
      .clk    (clk),
      .rst    (rst),
      .valid_i(databus_valid_o),
      .ready_i(databus_ready_i),
      .last_i (databus_last_i),
      .addr_i (databus_addr_o),
      .len_i  (databus_len_o),
      .data_i (databus_wdata_o),
      .done_i (done_o)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   function automatic int rand_below(input int n);
      return int'($unsigned($random(seed)) % n);
   endfunction

   task automatic check(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("ERROR %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
      end
   endtask

   // bus responder with random stalls and last on each burst's final beat
   task automatic respond_bus();
      databus_ready_i = (rand_below(4) != 0);
      databus_last_i  = 1'b0;
      if (databus_valid_o && databus_ready_i) begin
         beats++;
      end
      if (databus_valid_o) begin
         if (exp_data_q.size() == 0) begin
            errors++;
            $display("databus offered a beat although the whole block was already sent");
         end else begin
            check("beat_addr", 32'(exp_addr_q[0]), 32'(databus_addr_o));
            check("beat_len", 32'(exp_len_q[0]), 32'(databus_len_o));
            check("beat_data", 32'(exp_data_q[0]), 32'(databus_wdata_o));
            if (databus_ready_i) begin
               databus_last_i = exp_final_q[0];
               exp_addr_q.delete(0);
               exp_len_q.delete(0);
               exp_data_q.delete(0);
               exp_final_q.delete(0);
            end
         end
      end
   endtask

   task automatic step_cycle(input logic store_on);
      logic              we;
      logic [ADDR_W-1:0] a;

      in_data_i = DATA_W'($random(seed));
      if (store_on && store_we_q.size() > 0) begin
         we = store_we_q.pop_front();
         a  = store_addr_q.pop_front();
         if (we) begin
            model_mem[a] = in_data_i;
         end
      end
      respond_bus();
   endtask

   // fills one whole half with consecutive addresses
   task automatic fill_config();
      ping_pong_i        = 1'b1;
      enabled_i          = 1'b0;
      start_i            = '0;
      incr_i             = ADDR_W'(1);
      shift_i            = '0;
      per_i              = PERIOD_W'(32);
      duty_i             = PERIOD_W'(32);
      iter_i             = ADDR_W'(HALF_WORDS / 32);
      delay_i            = '0;
      ext_addr_i         = '0;
      amount_minus_one_i = '0;
      length_i           = LEN_W'(1);
   endtask

   task automatic pick_config();
      ping_pong_i        = (rand_below(6) != 0);
      enabled_i          = ping_pong_i ? (rand_below(5) != 0) : 1'b0;
      start_i            = ADDR_W'(rand_below(256));
      incr_i             = ADDR_W'(rand_below(4));
      shift_i            = ADDR_W'(rand_below(256));
      iter_i             = ADDR_W'(rand_below(9));
      per_i              = PERIOD_W'(rand_below(17));
      duty_i             = PERIOD_W'(rand_below(18));
      delay_i            = DELAY_W'(rand_below(64));
      ext_addr_i         = AXI_ADDR_W'(rand_below(1 << 20) * 4);
      amount_minus_one_i = ADDR_W'(rand_below(HALF_WORDS));
      length_i           = LEN_W'(rand_below(16) + 1);
   endtask

   task automatic execute_run();
      int                p_eff;
      int                i_eff;
      int                n_words;
      int                len;
      int                b;
      int                rem;
      logic [ADDR_W-1:0] a;
      logic [ADDR_W-1:0] rd;

      @(negedge clk);
      // stores go to the new half while the drain reads the other one
      model_half = ping_pong_i ? ~model_half : 1'b0;
      n_words = enabled_i ? int'(amount_minus_one_i) + 1 : 0;
      len = int'(length_i);
      for (int k = 0; k < n_words; k++) begin
         b = k / len;
         rem = n_words - b * len;
         rd = ping_pong_i ? {~model_half, k[ADDR_W-2:0]} : ADDR_W'(k);
         exp_addr_q.push_back(ext_addr_i + AXI_ADDR_W'(b * len * BYTES_PER_WORD));
         exp_len_q.push_back(LEN_W'((rem < len) ? rem : len));
         exp_data_q.push_back(model_mem[rd]);
         exp_final_q.push_back((k % len == len - 1) || (k == n_words - 1));
      end
      // one store entry per cycle after run
      p_eff = (per_i == 0) ? 1 : int'(per_i);
      i_eff = (iter_i == 0) ? 1 : int'(iter_i);
      for (int k = 0; k < int'(delay_i); k++) begin
         store_we_q.push_back(1'b0);
         store_addr_q.push_back('0);
      end
      for (int k = 0; k < p_eff * i_eff; k++) begin
         a = ADDR_W'(int'(start_i) + k * int'(incr_i) + (k / p_eff) * int'(shift_i));
         if (ping_pong_i) begin
            a[ADDR_W-1] = model_half;
         end
         store_we_q.push_back((k % p_eff) < int'(duty_i));
         store_addr_q.push_back(a);
      end
      beats = 0;
      run_i = 1'b1;
      step_cycle(1'b0);
      @(negedge clk);
      run_i = 1'b0;
      check("done_low_after_run", 0, 32'(done_o));
      while (!done_o) begin
         step_cycle(1'b1);
         @(negedge clk);
      end
      check("store_steps_left", 0, 32'(store_we_q.size()));
      check("beats_left", 0, 32'(exp_data_q.size()));
      check("beat_count", 32'(n_words), 32'(beats));
      store_we_q.delete();
      store_addr_q.delete();
      exp_addr_q.delete();
      exp_len_q.delete();
      exp_data_q.delete();
      exp_final_q.delete();
   endtask

   initial begin
      rst             = 1'b1;
      run_i           = 1'b0;
      running_i       = 1'b0;
      in_data_i       = '0;
      databus_ready_i = 1'b0;
      databus_last_i  = 1'b0;
      model_half      = 1'b0;
      fill_config();
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst       = 1'b0;
      running_i = 1'b1;
      check("done_after_reset", 1, 32'(done_o));
      check("valid_after_reset", 0, 32'(databus_valid_o));
      // both halves get known contents before anything is drained
      for (int r = 0; r < 2; r++) begin
         fill_config();
         execute_run();
      end
      for (int r = 0; r < NUM_RUNS; r++) begin
         pick_config();
         execute_run();
      end
      $display("runs: %0d, checks: %0d, errors: %0d, assertion failures: %0d",
               NUM_RUNS + 2, checks, errors, DUT.u_chk.failures);
      if (errors == 0 && DUT.u_chk.failures == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("watchdog expired, done never came back high for the current run");
      $display(">>> FAIL");
      $finish;
   end

endmodule

// ==== vwrite.f ====
hw/vwrite_pkg.sv
hw/vwrite_stream_if.sv
hw/vwrite_ctrl.sv
hw/store_addr_gen.sv
hw/dual_port_buffer.sv
hw/buffer_reader.sv
hw/burst_writer.sv
hw/vwrite_top.sv
verif/vwrite_chk.sv
verif/vwrite_tb.sv
